// ==== src/sonar_pkg.sv ====
package sonar_pkg;

	typedef logic signed [7:0]  sample_t;   // microphone sample
	typedef logic signed [15:0] audio_t;    // speaker sample
	typedef logic [15:0]        energy_t;   // rectified energy over one window
	typedef logic [7:0]         delay_t;    // round trip in sample periods

	localparam int SAMPLE_DIV    = 8;
	localparam int WINDOW_SIZE   = 16;
	localparam int MAX_DELAY     = 240;
	localparam int BURST_LEN     = 32;
	localparam int RETRY_GAP     = 32;
	localparam int CONFIRM_COUNT = 3;

	localparam audio_t PING_AMPLITUDE = 16'sd16384;

	// counter widths and terminal counts
	localparam int DIV_W    = $clog2(SAMPLE_DIV);
	localparam int WINDOW_W = $clog2(WINDOW_SIZE);
	localparam int BURST_W  = $clog2(BURST_LEN + 1);
	localparam int GAP_W    = $clog2(RETRY_GAP);
	localparam int HIST_W   = $clog2(CONFIRM_COUNT);

	localparam logic [DIV_W-1:0]    DIV_LAST    = DIV_W'(SAMPLE_DIV - 1);
	localparam logic [WINDOW_W-1:0] WINDOW_LAST = WINDOW_W'(WINDOW_SIZE - 1);
	localparam logic [BURST_W-1:0]  BURST_END   = BURST_W'(BURST_LEN);
	localparam logic [GAP_W-1:0]    GAP_LAST    = GAP_W'(RETRY_GAP - 1);
	localparam logic [HIST_W-1:0]   HIST_FULL   = HIST_W'(CONFIRM_COUNT - 1);
	localparam delay_t              MAX_INDEX   = delay_t'(MAX_DELAY);

	typedef enum logic [2:0] {
		IDLE,
		START_PING,
		AWAIT_PING,
		LISTEN,
		GAP
	} ranging_state_t;

endpackage

// ==== src/sample_tick.sv ====
`timescale 1ns/1ps

// one-cycle sample strobe every SAMPLE_DIV clocks
module sample_tick (
	input  logic clk_in,
	input  logic rst_in,
	output logic step
);

	logic [sonar_pkg::DIV_W-1:0] div_count;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			div_count <= '0;
			step      <= 1'b0;
		end else begin
			step <= (div_count == sonar_pkg::DIV_LAST);  // pulse on wrap
			if (div_count == sonar_pkg::DIV_LAST) begin
				div_count <= '0;
			end else begin
				div_count <= div_count + 1'b1;
			end
		end
	end

endmodule

// ==== src/impulse_generator.sv ====
`timescale 1ns/1ps

// square-wave ping, two samples per half period
module impulse_generator (
	input  logic              clk_in,
	input  logic              rst_in,
	input  logic              step,
	input  logic              ping_start,
	output logic              burst_begin,
	output sonar_pkg::audio_t amp_out
);

	logic                          armed;        // waiting for the next strobe
	logic                          playing;
	logic [sonar_pkg::BURST_W-1:0] sample_count; // index of the next burst sample

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			armed        <= 1'b0;
			playing      <= 1'b0;
			sample_count <= '0;
			burst_begin  <= 1'b0;
			amp_out      <= '0;
		end else begin
			burst_begin <= 1'b0;
			if (ping_start) begin
				armed <= 1'b1;
			end
			if (step) begin
				if (armed) begin
					// first sample goes out together with burst_begin
					armed        <= 1'b0;
					playing      <= 1'b1;
					burst_begin  <= 1'b1;
					sample_count <= 1;
					amp_out      <= sonar_pkg::PING_AMPLITUDE;
				end else if (playing) begin
					if (sample_count == sonar_pkg::BURST_END) begin
						playing <= 1'b0;
						amp_out <= '0;   // silence after the burst
					end else begin
						sample_count <= sample_count + 1'b1;
						amp_out      <= sample_count[1] ? -sonar_pkg::PING_AMPLITUDE
						                                : sonar_pkg::PING_AMPLITUDE;
					end
				end
			end
		end
	end

	// the controller must wait for the previous burst to finish
	a_no_overlap: assert property (@(posedge clk_in) disable iff (rst_in)
		ping_start |-> !(armed || playing));

endmodule

// ==== src/transient_detector.sv ====
`timescale 1ns/1ps

// windowed energy onset detector
// a window is an onset when it beats the previous one and 1.5x the one before that
module transient_detector (
	input  logic               clk_in,
	input  logic               rst_in,
	input  logic               step,
	input  logic               listen_clear,
	input  logic               listening,
	input  sonar_pkg::sample_t mic_in,
	output logic               onset,
	output logic               expired,
	output sonar_pkg::delay_t  onset_index
);

	logic [sonar_pkg::WINDOW_W-1:0] win_count;  // samples taken in the current window
	sonar_pkg::delay_t              sample_index;
	sonar_pkg::energy_t             cur_sum;
	sonar_pkg::energy_t             prev_sum;
	sonar_pkg::energy_t             prev_prev_sum;

	logic signed [8:0]  mic_ext;
	logic [8:0]         mic_mag;
	sonar_pkg::energy_t window_sum;    // running sum including this sample
	sonar_pkg::delay_t  next_index;
	logic [16:0]        pp_threshold;  // one bit wider so the sentinel cannot wrap
	logic               window_done;
	logic               is_onset;

	assign mic_ext      = {mic_in[7], mic_in};
	assign mic_mag      = mic_ext[8] ? -mic_ext : mic_ext;  // rectify
	assign window_sum   = cur_sum + sonar_pkg::energy_t'(mic_mag);
	assign next_index   = sample_index + 8'd1;
	assign window_done  = (win_count == sonar_pkg::WINDOW_LAST);

	assign pp_threshold = {1'b0, prev_prev_sum} + {2'b00, prev_prev_sum[15:1]};
	assign is_onset     = (window_sum > prev_sum) && ({1'b0, window_sum} > pp_threshold);

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			win_count    <= '0;
			sample_index <= '0;
			onset        <= 1'b0;
			expired      <= 1'b0;
		end else begin
			onset   <= 1'b0;
			expired <= 1'b0;
			if (listen_clear) begin
				win_count    <= '0;
				sample_index <= '0;
			end else if (listening && step) begin
				sample_index <= next_index;
				win_count    <= window_done ? '0 : win_count + 1'b1;
				if (window_done && is_onset) begin
					onset <= 1'b1;
				end else if (next_index == sonar_pkg::MAX_INDEX) begin
					expired <= 1'b1;   // nothing heard within range
				end
			end
		end
	end

	// energy of the current and the last two windows
	always_ff @(posedge clk_in) begin
		if (listen_clear) begin
			cur_sum       <= '0;
			prev_sum      <= '1;   // all-ones blocks the first two windows
			prev_prev_sum <= '1;
		end else if (listening && step) begin
			if (window_done) begin
				cur_sum       <= '0;
				prev_sum      <= window_sum;
				prev_prev_sum <= prev_sum;
				onset_index   <= next_index;  // multiple of WINDOW_SIZE
			end else begin
				cur_sum <= window_sum;
			end
		end
	end

	a_onset_xor_expired: assert property (@(posedge clk_in) disable iff (rst_in)
		!(onset && expired));

	// results only come out of a listening period opened by the controller
	a_result_while_listening: assert property (@(posedge clk_in) disable iff (rst_in)
		(onset || expired) |-> listening);

endmodule

// ==== src/sos_dist_calculator.sv ====
`timescale 1ns/1ps

// ranging controller
// pings repeatedly until CONFIRM_COUNT onsets in a row agree
module sos_dist_calculator (
	input  logic              clk_in,
	input  logic              rst_in,
	input  logic              trigger,
	input  logic              step,
	input  logic              burst_begin,
	input  logic              onset,
	input  logic              expired,
	input  sonar_pkg::delay_t onset_index,
	output logic              ping_start,
	output logic              listen_clear,
	output logic              listening,
	output logic              no_echo,
	output logic              delay_valid,
	output sonar_pkg::delay_t delay
);

	sonar_pkg::ranging_state_t state;

	sonar_pkg::delay_t             hist_last;  // most recent onset index
	sonar_pkg::delay_t             hist_prev;  // the one before
	logic [sonar_pkg::HIST_W-1:0]  hist_fill;  // valid history entries
	logic [sonar_pkg::GAP_W-1:0]   gap_count;  // strobes spent in GAP
	logic                          confirmed;

	assign ping_start = (state == sonar_pkg::START_PING);

	// the new onset agrees with both stored results
	assign confirmed = (hist_fill == sonar_pkg::HIST_FULL) &&
	                   (hist_last == onset_index) &&
	                   (hist_prev == onset_index);

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			state        <= sonar_pkg::IDLE;
			hist_fill    <= '0;
			gap_count    <= '0;
			listen_clear <= 1'b0;
			listening    <= 1'b0;
			no_echo      <= 1'b0;
			delay_valid  <= 1'b0;
			delay        <= '0;
		end else begin
			listen_clear <= 1'b0;
			no_echo      <= 1'b0;
			case (state)
				sonar_pkg::IDLE: begin
					if (trigger) begin
						hist_fill   <= '0;
						delay_valid <= 1'b0;
						state       <= sonar_pkg::START_PING;
					end
				end
				sonar_pkg::START_PING: begin
					state <= sonar_pkg::AWAIT_PING;   // ping_start is high for this one cycle
				end
				sonar_pkg::AWAIT_PING: begin
					if (burst_begin) begin
						listen_clear <= 1'b1;
						listening    <= 1'b1;
						state        <= sonar_pkg::LISTEN;
					end
				end
				sonar_pkg::LISTEN: begin
					if (onset) begin
						listening <= 1'b0;
						if (confirmed) begin
							delay       <= onset_index;
							delay_valid <= 1'b1;
							hist_fill   <= '0;
							state       <= sonar_pkg::IDLE;
						end else begin
							hist_prev <= hist_last;
							hist_last <= onset_index;
							if (hist_fill != sonar_pkg::HIST_FULL) begin
								hist_fill <= hist_fill + 1'b1;
							end
							gap_count <= '0;
							state     <= sonar_pkg::GAP;
						end
					end else if (expired) begin
						// no echo in range, give up on this measurement
						listening <= 1'b0;
						hist_fill <= '0;
						no_echo   <= 1'b1;
						state     <= sonar_pkg::IDLE;
					end
				end
				sonar_pkg::GAP: begin
					if (step) begin
						if (gap_count == sonar_pkg::GAP_LAST) begin
							state <= sonar_pkg::START_PING;
						end else begin
							gap_count <= gap_count + 1'b1;
						end
					end
				end
				default: begin
					state <= sonar_pkg::IDLE;
				end
			endcase
		end
	end

	// a result is only published straight after a confirming onset
	a_valid_after_onset: assert property (@(posedge clk_in) disable iff (rst_in)
		$rose(delay_valid) |-> $past((state == sonar_pkg::LISTEN) && onset));

endmodule

// ==== src/sonar_top.sv ====
`timescale 1ns/1ps

// acoustic ranging subsystem
module sonar_top (
	input  logic               clk_in,
	input  logic               rst_in,
	input  logic               trigger,
	input  sonar_pkg::sample_t mic_in,
	output sonar_pkg::audio_t  amp_out,
	output logic               sample_strobe,
	output sonar_pkg::delay_t  delay,
	output logic               delay_valid,
	output logic               no_echo
);

	logic              ping_start;
	logic              burst_begin;
	logic              listen_clear;
	logic              listening;
	logic              onset;
	logic              expired;
	sonar_pkg::delay_t onset_index;

	sample_tick u_tick (
		.clk_in (clk_in),
		.rst_in (rst_in),
		.step   (sample_strobe)   // also paces the audio stream outside
	);

	impulse_generator u_gen (
		.clk_in      (clk_in),
		.rst_in      (rst_in),
		.step        (sample_strobe),
		.ping_start  (ping_start),
		.burst_begin (burst_begin),
		.amp_out     (amp_out)
	);

	transient_detector u_det (
		.clk_in       (clk_in),
		.rst_in       (rst_in),
		.step         (sample_strobe),
		.listen_clear (listen_clear),
		.listening    (listening),
		.mic_in       (mic_in),
		.onset        (onset),
		.expired      (expired),
		.onset_index  (onset_index)
	);

	sos_dist_calculator u_ctrl (
		.clk_in       (clk_in),
		.rst_in       (rst_in),
		.trigger      (trigger),
		.step         (sample_strobe),
		.burst_begin  (burst_begin),
		.onset        (onset),
		.expired      (expired),
		.onset_index  (onset_index),
		.ping_start   (ping_start),
		.listen_clear (listen_clear),
		.listening    (listening),
		.no_echo      (no_echo),
		.delay_valid  (delay_valid),
		.delay        (delay)
	);

endmodule

// ==== tb/echo_model.sv ====
`timescale 1ns/1ps

// behavioural room, the speaker signal comes back to the microphone lag samples later
module echo_model (
	input  logic               clk_in,
	input  logic               rst_in,
	input  logic               sample_strobe,
	input  sonar_pkg::audio_t  amp_out,
	input  sonar_pkg::delay_t  lag,       // 0 gives a room with no reflector
	output sonar_pkg::sample_t mic_in
);

	sonar_pkg::sample_t ring [256];
	logic [7:0]         wr_ptr;
	logic [7:0]         fill;         // samples written since the last lag change
	sonar_pkg::delay_t  lag_q;

	always_ff @(posedge clk_in) begin
		if (rst_in || (lag != lag_q)) begin
			// a new room, nothing of the old one is heard
			wr_ptr <= '0;
			fill   <= '0;
			lag_q  <= lag;
		end else if (sample_strobe) begin
			ring[wr_ptr] <= amp_out[15:8];   // attenuated by 256
			wr_ptr       <= wr_ptr + 8'd1;
			if (fill != 8'hff) begin
				fill <= fill + 8'd1;
			end
		end
	end

	// oldest sample still inside the lag window, silence until the line has filled
	assign mic_in = ((lag_q != '0) && (fill >= lag_q)) ? ring[wr_ptr - lag_q] : '0;

endmodule

// ==== tb/sonar_tb.sv ====
`timescale 1ns/1ps

module sonar_tb;

	localparam int ROWS           = 8;
	localparam int PING_TIMEOUT   = 100;     // cycles from trigger to the first burst sample
	localparam int RESULT_TIMEOUT = 20000;   // three full listens and two gaps fit easily

	// each row holds the echo lag in samples, the expected delay, whether an echo
	// comes back and whether a second trigger is pulsed mid-measurement
	// expected delay is WINDOW_SIZE * (lag / WINDOW_SIZE + 1)
	localparam int LAG_TAB    [ROWS] = '{0, 40, 95, 128, 224, 173, 0, 64};
	localparam int EXP_TAB    [ROWS] = '{0, 48, 96, 144, 240, 176, 0, 80};
	localparam bit ECHO_TAB   [ROWS] = '{0, 1, 1, 1, 1, 1, 0, 1};
	localparam bit RETRIG_TAB [ROWS] = '{0, 0, 0, 1, 0, 1, 0, 0};

	logic               clk_in;
	logic               rst_in;
	logic               trigger;
	sonar_pkg::sample_t mic_in;
	sonar_pkg::audio_t  amp_out;
	logic               sample_strobe;
	sonar_pkg::delay_t  delay;
	logic               delay_valid;
	logic               no_echo;
	sonar_pkg::delay_t  lag;                 // echo lag of the room model

	int ping_count   = 0;                    // bursts seen since the last trigger
	int last_delay   = 0;                    // held through rows without an echo
	bit burst_active = 1'b0;
	int strobe_gap   = 0;                    // clocks since the last sample strobe
	bit strobe_seen  = 1'b0;

	sonar_top  dut  (.*);
	echo_model room (.*);

	initial begin
		clk_in = 1'b0;
		forever begin
			#50 clk_in = ~clk_in;
		end
	end

	task automatic stop_on_error(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_equal(input int actual, input int expected, input string what);
		if (actual != expected) begin
			stop_on_error($sformatf("[FAIL] %0t ns: %s is %0d, expected %0d",
			                        $time, what, actual, expected));
		end
	endtask

	// every non-zero speaker sample belongs to a ping at full amplitude
	always @(negedge clk_in) begin
		if (!rst_in && amp_out != 0) begin
			check_equal((amp_out < 0) ? -int'(amp_out) : int'(amp_out),
			            int'(sonar_pkg::PING_AMPLITUDE), "ping magnitude");
			if (!burst_active) begin
				ping_count++;
			end
		end
		burst_active = (amp_out != 0);
	end

	// the sample strobe is a one-cycle pulse every SAMPLE_DIV clocks
	always @(negedge clk_in) begin
		if (rst_in) begin
			check_equal(int'(sample_strobe), 0, "sample_strobe in reset");
			strobe_gap  = 0;
			strobe_seen = 1'b0;
		end else begin
			strobe_gap++;
			if (sample_strobe) begin
				if (strobe_seen) begin
					check_equal(strobe_gap, sonar_pkg::SAMPLE_DIV, "sample strobe period");
				end
				strobe_gap  = 0;
				strobe_seen = 1'b1;
			end
		end
	end

	// waits on falling edges until a ping or a result shows up
	task automatic await_output(input bit for_result, input int limit, input string what);
		int cycles;
		bit seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < limit) begin
			@(negedge clk_in);
			cycles++;
			seen = for_result ? (delay_valid || no_echo) : (amp_out != 0);
		end
		if (!seen) begin
			stop_on_error($sformatf("timeout: no %s within %0d cycles", what, limit));
		end
	endtask

	// all outputs hold still over some idle strobes
	task automatic watch_quiet(input int strobes, input bit valid_level, input int held_delay);
		int seen;
		int cycles;
		seen   = 0;
		cycles = 0;
		while (seen < strobes && cycles < 2 * strobes * sonar_pkg::SAMPLE_DIV) begin
			@(negedge clk_in);
			cycles++;
			if (sample_strobe) begin
				seen++;
			end
			check_equal(int'(delay_valid), int'(valid_level), "delay_valid while idle");
			check_equal(int'(no_echo), 0, "no_echo while idle");
			check_equal(int'(delay), held_delay, "delay while idle");
			check_equal(int'(amp_out), 0, "amp_out while idle");
		end
		if (seen < strobes) begin
			stop_on_error("timeout: sample_strobe stopped pulsing");
		end
	endtask

	initial begin
		void'($urandom(38));
		rst_in  = 1'b1;
		trigger = 1'b0;
		lag     = '0;
		repeat (8) @(posedge clk_in);
		rst_in <= 1'b0;

		watch_quiet(6, 1'b0, 0);   // outputs straight after reset

		for (int row = 0; row < ROWS; row++) begin
			@(posedge clk_in);
			lag <= sonar_pkg::delay_t'(LAG_TAB[row]);
			repeat (2) @(posedge clk_in);    // room model restarts on a lag change
			trigger    <= 1'b1;
			ping_count = 0;
			@(posedge clk_in);
			trigger <= 1'b0;
			@(negedge clk_in);
			check_equal(int'(delay_valid), 0, "delay_valid after trigger");
			await_output(1'b0, PING_TIMEOUT, "ping after the trigger");
			if (RETRIG_TAB[row]) begin
				// a trigger mid-measurement is ignored
				@(posedge clk_in);
				trigger <= 1'b1;
				@(posedge clk_in);
				trigger <= 1'b0;
			end
			await_output(1'b1, RESULT_TIMEOUT, "measurement result");
			if (ECHO_TAB[row]) begin
				check_equal(int'(delay_valid), 1, "delay_valid");
				check_equal(int'(delay), EXP_TAB[row], "delay");
				check_equal(ping_count, sonar_pkg::CONFIRM_COUNT, "pings per measurement");
				last_delay = EXP_TAB[row];
			end else begin
				check_equal(int'(no_echo), 1, "no_echo");
				check_equal(int'(delay_valid), 0, "delay_valid without echo");
				check_equal(int'(delay), last_delay, "delay without echo");
				check_equal(ping_count, 1, "pings without echo");
			end
			watch_quiet($urandom_range(12, 2), ECHO_TAB[row], last_delay);
		end

		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== tb.f ====
src/sonar_pkg.sv
src/sample_tick.sv
src/impulse_generator.sv
src/transient_detector.sv
src/sos_dist_calculator.sv
src/sonar_top.sv
tb/echo_model.sv
tb/sonar_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = sonar_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
